//--- rtl/mips_pkg.sv
// MIPS core shared types
package mips_pkg;

  // ----------------------------------------------------------
  // Instruction encodings
  // ----------------------------------------------------------

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDIU = 6'h09,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // R-type function field
  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  // Internal ALU operation, add is the idle default
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  // Register format view
  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_e     funct;
  } r_fields_t;

  // Immediate format view
  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fields_t;

  // Same instruction word, two decodings
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  // ----------------------------------------------------------
  // Control word and stage bundles
  // ----------------------------------------------------------

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    branch;
  } ctrl_t;

  // Fetch to decode
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instr_u      instr;
  } fd_t;

  // Decode to execute, operands already forwarded
  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] store_data;
    logic [31:0] imm;
    logic [4:0]  dest;
  } de_t;

  // Execute to memory
  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] result;
    logic [31:0] store_data;
    logic [4:0]  dest;
  } em_t;

  // Register file write port
  typedef struct packed {
    logic        we;
    logic [4:0]  dest;
    logic [31:0] data;
  } wb_t;

endpackage

//--- rtl/mips_fetch.sv
// Instruction fetch stage
`timescale 1ns/1ps

module mips_fetch #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          stall,
  input  logic          redirect,
  input  logic [31:0]   target,
  output logic [31:0]   pc_rom,
  input  logic [31:0]   inst_rom,
  output mips_pkg::fd_t fd
);

  logic [31:0] pc_q;
  logic        fd_valid_q;
  logic [31:0] fd_pc_q;
  logic [31:0] fd_instr_q;

  // ROM is addressed straight from the PC
  assign pc_rom = pc_q;

  // Program counter
  // Branch target wins over the stall hold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect) begin
      pc_q <= target;
    end else if (!stall) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Fetch/decode valid, killed by a taken branch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fd_valid_q <= 1'b0;
    end else if (redirect) begin
      fd_valid_q <= 1'b0;
    end else if (!stall) begin
      fd_valid_q <= 1'b1;
    end
  end

  // Fetched word and its address, held while stalled
  always_ff @(posedge clk) begin
    if (!stall) begin
      fd_pc_q    <= pc_q;
      fd_instr_q <= inst_rom;
    end
  end

  always_comb begin
    fd.valid = fd_valid_q;
    fd.pc    = fd_pc_q;
    fd.instr = fd_instr_q;
  end

endmodule

//--- rtl/mips_decode.sv
// Decode and register read stage
`timescale 1ns/1ps

module mips_decode (
  input  logic          clk,
  input  logic          rst_n,
  input  mips_pkg::fd_t fd,
  input  mips_pkg::em_t ex_fwd,
  input  mips_pkg::wb_t wb,
  input  logic          flush,
  output logic          stall,
  output mips_pkg::de_t de
);

  logic [31:0]      regs [32];
  mips_pkg::instr_u ins;
  mips_pkg::ctrl_t  ctrl;
  mips_pkg::de_t    de_next;
  mips_pkg::de_t    de_q;
  logic             de_valid_q;
  logic [4:0]       rs;
  logic [4:0]       rt;
  logic             uses_rt;
  logic [31:0]      rf_a;
  logic [31:0]      rf_b;

  // Operand source priority: execute, then writeback, then file
  function automatic logic [31:0] fwd_sel(input logic [4:0] src, input logic [31:0] rf,
                                          input mips_pkg::em_t ex, input mips_pkg::wb_t w);
    logic ex_hit;
    ex_hit = ex.valid && ex.ctrl.reg_write && !ex.ctrl.mem_read &&
             (ex.dest != 5'd0) && (ex.dest == src);
    if (ex_hit) begin
      return ex.result;
    end else if (w.we && (w.dest == src)) begin
      return w.data;
    end
    return rf;
  endfunction

  // ----------------------------------------------------------
  // Register file
  // ----------------------------------------------------------
  // wb.we is never set for r0
  always_ff @(posedge clk) begin
    if (wb.we) begin
      regs[wb.dest] <= wb.data;
    end
  end

  assign ins  = fd.instr;
  assign rs   = ins.r.rs;
  assign rt   = ins.i.rt;
  // r0 reads as zero
  assign rf_a = (rs == 5'd0) ? 32'd0 : regs[rs];
  assign rf_b = (rt == 5'd0) ? 32'd0 : regs[rt];

  // ----------------------------------------------------------
  // Control decode
  // ----------------------------------------------------------
  always_comb begin
    ctrl = '0;
    case (ins.i.opcode)
      mips_pkg::OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        case (ins.r.funct)
          mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
          // Unsupported funct acts as a nop
          default:           ctrl.reg_write = 1'b0;
        endcase
      end
      mips_pkg::OP_ADDIU: begin
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      mips_pkg::OP_LW: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      mips_pkg::OP_SW: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      mips_pkg::OP_BEQ: begin
        ctrl.alu_op = mips_pkg::ALU_SUB;
        ctrl.branch = 1'b1;
      end
      default: ;
    endcase
  end

  // rt is a source for R-type, SW and BEQ only
  assign uses_rt = !ctrl.use_imm || ctrl.mem_write;

  // Load in execute feeding this instruction
  assign stall = fd.valid && de.valid && de.ctrl.mem_read && (de.dest != 5'd0) &&
                 ((de.dest == rs) || (uses_rt && (de.dest == rt)));

  always_comb begin
    de_next            = '0;
    de_next.valid      = fd.valid;
    de_next.ctrl       = ctrl;
    de_next.pc         = fd.pc;
    de_next.op_a       = fwd_sel(rs, rf_a, ex_fwd, wb);
    de_next.op_b       = fwd_sel(rt, rf_b, ex_fwd, wb);
    de_next.store_data = de_next.op_b;
    de_next.imm        = {{16{ins.i.imm[15]}}, ins.i.imm};
    de_next.dest       = (ins.i.opcode == mips_pkg::OP_RTYPE) ? ins.r.rd : rt;
  end

  // ----------------------------------------------------------
  // Decode/execute register
  // ----------------------------------------------------------
  // Bubble on stall or taken branch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_valid_q <= 1'b0;
    end else begin
      de_valid_q <= fd.valid && !stall && !flush;
    end
  end

  always_ff @(posedge clk) begin
    de_q <= de_next;
  end

  always_comb begin
    de       = de_q;
    de.valid = de_valid_q;
  end

endmodule

//--- rtl/mips_execute.sv
// Execute stage with ALU and branch
`timescale 1ns/1ps

module mips_execute (
  input  logic          clk,
  input  logic          rst_n,
  input  mips_pkg::de_t de,
  output mips_pkg::em_t em,
  output mips_pkg::em_t fwd,
  output logic          redirect,
  output logic [31:0]   target
);

  logic [31:0]   alu_b;
  logic [31:0]   result;
  mips_pkg::em_t em_next;
  mips_pkg::em_t em_q;
  logic          em_valid_q;

  // Immediate replaces rt for ADDIU, LW and SW
  assign alu_b = de.ctrl.use_imm ? de.imm : de.op_b;

  always_comb begin
    case (de.ctrl.alu_op)
      mips_pkg::ALU_SUB: result = de.op_a - alu_b;
      mips_pkg::ALU_AND: result = de.op_a & alu_b;
      mips_pkg::ALU_OR:  result = de.op_a | alu_b;
      // Signed compare
      mips_pkg::ALU_SLT: result = {31'd0, $signed(de.op_a) < $signed(alu_b)};
      default:           result = de.op_a + alu_b;
    endcase
  end

  // BEQ resolves here, no delay slot
  assign redirect = de.valid && de.ctrl.branch && (de.op_a == de.op_b);
  assign target   = de.pc + 32'd4 + {de.imm[29:0], 2'b00};

  always_comb begin
    em_next            = '0;
    em_next.valid      = de.valid;
    em_next.ctrl       = de.ctrl;
    em_next.result     = result;
    em_next.store_data = de.store_data;
    em_next.dest       = de.dest;
  end

  // Unregistered result back to decode
  assign fwd = em_next;

  // ----------------------------------------------------------
  // Execute/memory register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      em_valid_q <= 1'b0;
    end else begin
      em_valid_q <= de.valid;
    end
  end

  always_ff @(posedge clk) begin
    em_q <= em_next;
  end

  always_comb begin
    em       = em_q;
    em.valid = em_valid_q;
  end

endmodule

//--- rtl/mips_mem_wb.sv
// Memory access and writeback stage
`timescale 1ns/1ps

module mips_mem_wb (
  input  mips_pkg::em_t em,
  output logic [31:0]   ram_adr,
  output logic [31:0]   ram_data,
  output logic          ram_read,
  output logic          ram_write,
  input  logic [31:0]   ram_word,
  output mips_pkg::wb_t wb
);

  // Word address and store data straight from execute
  assign ram_adr  = em.result;
  assign ram_data = em.store_data;

  // Strobes only for a live instruction
  // Store lasts exactly this one cycle
  assign ram_read  = em.valid && em.ctrl.mem_read;
  assign ram_write = em.valid && em.ctrl.mem_write;

  // Writeback select
  // Load data arrives in the same cycle
  always_comb begin
    wb.we   = em.valid && em.ctrl.reg_write && (em.dest != 5'd0);
    wb.dest = em.dest;
    if (em.ctrl.mem_read) begin
      wb.data = ram_word;
    end else begin
      wb.data = em.result;
    end
  end

endmodule

//--- rtl/mips_core.sv
// MIPS pipelined core top level
`timescale 1ns/1ps

module mips_core #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  // Instruction ROM
  output logic [31:0] pc_rom,
  input  logic [31:0] inst_rom,
  // Data RAM
  output logic        ram_read,
  output logic        ram_write,
  output logic [31:0] ram_data,
  input  logic [31:0] ram_word,
  output logic [31:0] ram_adr
);

  mips_pkg::fd_t fd;
  mips_pkg::de_t de;
  mips_pkg::em_t em;
  mips_pkg::em_t ex_fwd;
  mips_pkg::wb_t wb;
  logic          stall;
  logic          redirect;
  logic [31:0]   target;

  // ----------------------------------------------------------
  // Stage chain
  // ----------------------------------------------------------
  mips_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .target   (target),
    .pc_rom   (pc_rom),
    .inst_rom (inst_rom),
    .fd       (fd)
  );

  // Taken branch also clears decode/execute
  mips_decode decode_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .fd     (fd),
    .ex_fwd (ex_fwd),
    .wb     (wb),
    .flush  (redirect),
    .stall  (stall),
    .de     (de)
  );

  mips_execute execute_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .de       (de),
    .em       (em),
    .fwd      (ex_fwd),
    .redirect (redirect),
    .target   (target)
  );

  mips_mem_wb mem_wb_inst (
    .em        (em),
    .ram_adr   (ram_adr),
    .ram_data  (ram_data),
    .ram_read  (ram_read),
    .ram_write (ram_write),
    .ram_word  (ram_word),
    .wb        (wb)
  );

endmodule

//--- testbench/mips_core_assert.sv
// Core memory port assertions
`timescale 1ns/1ps

module mips_core_assert (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] pc_rom,
  input logic        ram_read,
  input logic        ram_write
);

  // Load and store never share a cycle
  strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_read && ram_write))
    else $error("ram_read and ram_write are high together");

  // Fetch address on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc_rom[1:0] == 2'b00)
    else $error("pc_rom is not word aligned");

  // Strobes resolved once out of reset
  strobe_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({ram_read, ram_write}))
    else $error("a RAM strobe is unknown");

endmodule

bind mips_core mips_core_assert core_assert_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .pc_rom    (pc_rom),
  .ram_read  (ram_read),
  .ram_write (ram_write)
);

//--- testbench/mips_tb.sv
// MIPS core testbench
`timescale 1ns/1ps

module mips_tb;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc_rom;
  logic [31:0] inst_rom;
  logic        ram_read;
  logic        ram_write;
  logic [31:0] ram_data;
  logic [31:0] ram_word;
  logic [31:0] ram_adr;

  // Raw data file words, then the ROM and RAM models
  logic [31:0] tdata [0:63];
  logic [31:0] rom [0:63];
  logic [31:0] ram [0:255];
  logic [31:0] rom_off;
  logic [31:0] prog_len;
  logic [31:0] store_cnt;
  int          store_idx;
  int          err_value;
  int          err_other;
  logic        pc_checked;

  mips_core #(
    .RESET_PC (RESET_PC)
  ) mips_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_rom    (pc_rom),
    .inst_rom  (inst_rom),
    .ram_read  (ram_read),
    .ram_write (ram_write),
    .ram_data  (ram_data),
    .ram_word  (ram_word),
    .ram_adr   (ram_adr)
  );

  // ----------------------------------------------------------
  // Clock and memory models
  // ----------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Past the program the ROM returns a nop
  assign rom_off  = pc_rom - RESET_PC;
  assign inst_rom = ({2'b00, rom_off[31:2]} < prog_len) ? rom[rom_off[7:2]] : 32'h0;
  // Read port drives data only while the load strobe is up
  assign ram_word = ram_read ? ram[ram_adr[9:2]] : 32'h0;

  // Word write at the end of the store cycle
  always @(posedge clk) begin
    if (rst_n && ram_write) begin
      ram[ram_adr[9:2]] <= ram_data;
    end
  end

  function automatic logic [31:0] word_at(input logic [31:0] pos);
    return tdata[pos[5:0]];
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      err_value++;
    end
  endtask

  task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error %s: expected pc %h, actual pc %h", name, exp, act);
      err_value++;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d wrong values, %0d other failures, %0d of %0d stores seen",
             err_value, err_other + int'(timed_out), store_idx, store_cnt);
    if (err_value == 0 && err_other == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // ----------------------------------------------------------
  // Store trace monitor
  // ----------------------------------------------------------
  // Mid-cycle sampling, outputs settled
  always @(negedge clk) begin
    if (!rst_n) begin
      if (ram_read || ram_write) begin
        $display("a RAM strobe was raised while reset was asserted");
        err_other++;
      end
    end else begin
      if (!pc_checked) begin
        check_pc("pc after reset", RESET_PC, pc_rom);
        pc_checked = 1'b1;
      end
      if (ram_write) begin
        if (store_idx < store_cnt) begin
          check_word($sformatf("store %0d address", store_idx),
                     word_at(2 + prog_len + 2 * store_idx), ram_adr);
          check_word($sformatf("store %0d data", store_idx),
                     word_at(3 + prog_len + 2 * store_idx), ram_data);
          store_idx++;
        end else begin
          $display("an extra store to address %h came after the expected trace", ram_adr);
          err_other++;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_n      <= 1'b0;
    store_idx  = 0;
    err_value  = 0;
    err_other  = 0;
    pc_checked = 1'b0;
    $readmemh("testbench/mips_testdata.hex", tdata);
    // Length, program, store count, pairs
    prog_len  = word_at(0);
    store_cnt = word_at(1 + prog_len);
    for (int i = 0; i < prog_len; i++) begin
      rom[i[5:0]] = word_at(1 + i);
    end
    // Fill keyed to the byte address
    for (int i = 0; i < 256; i++) begin
      ram[i[7:0]] <= 32'h5a5a_0000 ^ (i << 2);
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait (store_idx == store_cnt);
    // Tail window to catch stray stores
    repeat (20) @(posedge clk);
    finish_run(1'b0);
  end

  // Watchdog scaled to the program length
  initial begin
    @(posedge rst_n);
    repeat (prog_len * 4 + 50) @(posedge clk);
    $display("watchdog expired before all expected stores were seen");
    finish_run(1'b1);
  end

endmodule

//--- testbench/mips_testdata.hex
// Word 0 program length, then program words, then store count
// Then one expected store per line: address data
00000017
24010005 // addiu r1, r0, 5
2402fffd // addiu r2, r0, -3
00221821 // addu  r3, r1, r2
00612023 // subu  r4, r3, r1
0041282a // slt   r5, r2, r1
00243024 // and   r6, r1, r4
00413825 // or    r7, r2, r1
ac030040 // sw    r3, 0x40(r0)
ac040044 // sw    r4, 0x44(r0)
ac050048 // sw    r5, 0x48(r0)
ac06004c // sw    r6, 0x4c(r0)
ac070050 // sw    r7, 0x50(r0)
8c080044 // lw    r8, 0x44(r0)
01014821 // addu  r9, r8, r1 (load use)
ac090054 // sw    r9, 0x54(r0)
10220001 // beq   r1, r2, +1 (not taken)
ac010058 // sw    r1, 0x58(r0)
10690002 // beq   r3, r9, +2 (taken)
ac02005c // sw    r2, 0x5c(r0) (skipped)
ac020060 // sw    r2, 0x60(r0) (skipped)
0022502a // slt   r10, r1, r2
ac0a005c // sw    r10, 0x5c(r0)
1000ffff // beq   r0, r0, -1 (halt loop)
00000008
00000040 00000002
00000044 fffffffd
00000048 00000001
0000004c 00000005
00000050 fffffffd
00000054 00000002
00000058 00000005
0000005c 00000000

//--- compile.f
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_decode.sv
rtl/mips_execute.sv
rtl/mips_mem_wb.sv
rtl/mips_core.sv
testbench/mips_core_assert.sv
testbench/mips_tb.sv

//--- Makefile
# Verilator flow for the MIPS core testbench

TOP = mips_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
